// File: logic/scurvePkg.sv
`default_nettype none

package scurvePkg;

  //////////////////////////////////////////////////
  // Tick periods in Clk_5M cycles
  //////////////////////////////////////////////////

  // Count efficiency window tick, 1 kHz
  localparam int unsigned SLOW_TICK_CYCLES = 5000;
  // Inner stimulus for self-pedestal scans
  localparam int unsigned INNER_TICK_CYCLES = 46;

  localparam int unsigned SLOW_CNT_W = $clog2(SLOW_TICK_CYCLES);
  localparam int unsigned INNER_CNT_W = $clog2(INNER_TICK_CYCLES);

  //////////////////////////////////////////////////
  // ASIC and data path sizes
  //////////////////////////////////////////////////

  localparam int unsigned NUM_CHANNELS = 64;
  localparam int unsigned CHAN_W = $clog2(NUM_CHANNELS);

  // Local result FIFO
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Label word then count word
  localparam int unsigned WORDS_PER_POINT = 2;

  // Scan sequencer states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    WAIT_CFG,
    MEASURE,
    NEXT,
    DRAIN,
    DONE
  } scanState_t;

endpackage

`default_nettype wire

// File: logic/scanParamIf.sv
`timescale 1ns/10ps
`default_nettype none

// Scan parameters frozen at the start of a run
interface scanParamIf;

  logic        mode;              // 1 trigger efficiency, 0 count efficiency
  logic        innerClockEnable;
  logic        singleOr64Chn;     // 1 single channel
  logic [5:0]  singleTestChannel;
  logic        ctestOrInput;
  logic        unmaskAllChannel;
  logic [9:0]  startDac;
  logic [9:0]  endDac;
  logic [9:0]  dacStep;
  logic [15:0] cptMax;            // Tick limit for the chosen mode
  logic [3:0]  triggerDelay;
  logic        run;               // One cycle, parameters valid from here

  modport cfg (
    output mode, innerClockEnable, singleOr64Chn, singleTestChannel, ctestOrInput,
    output unmaskAllChannel, startDac, endDac, dacStep, cptMax, triggerDelay, run
  );

  modport seq (
    input singleOr64Chn, singleTestChannel, ctestOrInput, unmaskAllChannel,
    input startDac, endDac, dacStep, run
  );

  modport meas (
    input mode, cptMax, triggerDelay
  );

endinterface

`default_nettype wire

// File: logic/scanConfig.sv
`timescale 1ns/10ps
`default_nettype none

module scanConfig (
  input  wire        Clk_5M,
  input  wire        reset_n,
  input  wire        testStart,
  input  wire        triggerEfficiencyOrCountEfficiency,
  input  wire        innerClockEnable,
  input  wire        singleOr64Chn,
  input  wire [5:0]  singleTestChannel,
  input  wire        ctestOrInput,
  input  wire        unmaskAllChannel,
  input  wire [9:0]  startDac,
  input  wire [9:0]  endDac,
  input  wire [9:0]  dacStep,
  input  wire [15:0] cptMaxIn,
  input  wire [15:0] counterMaxIn,
  input  wire [3:0]  triggerDelay,
  scanParamIf.cfg    params
);

  // Start level history, bit 0 newest
  logic [1:0] startHist;
  logic       startEdge;

  assign startEdge = startHist[0] & ~startHist[1];

  // Run pulse and mode bits
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      startHist               <= 2'b00;
      params.run              <= 1'b0;
      params.mode             <= 1'b0;
      params.innerClockEnable <= 1'b0;
    end else begin
      startHist  <= {startHist[0], testStart};
      params.run <= startEdge;
      if (startEdge) begin
        params.mode             <= triggerEfficiencyOrCountEfficiency;
        params.innerClockEnable <= innerClockEnable;
      end
    end
  end

  // Remaining scan fields, frozen for the whole run
  always_ff @(posedge Clk_5M) begin
    if (startEdge) begin
      params.singleOr64Chn     <= singleOr64Chn;
      params.singleTestChannel <= singleTestChannel;
      params.ctestOrInput      <= ctestOrInput;
      params.unmaskAllChannel  <= unmaskAllChannel;
      params.startDac          <= startDac;
      params.endDac            <= endDac;
      params.dacStep           <= dacStep;
      params.triggerDelay      <= triggerDelay;
      // Stimulus ticks or window ticks
      params.cptMax <= triggerEfficiencyOrCountEfficiency ? cptMaxIn : counterMaxIn;
    end
  end

endmodule

`default_nettype wire

// File: logic/testClockGen.sv
`timescale 1ns/10ps
`default_nettype none

module testClockGen
  import scurvePkg::*;
(
  input  wire Clk_5M,
  input  wire reset_n,
  input  wire mode,
  input  wire innerClockEnable,
  input  wire restart,
  input  wire clkExt,
  output wire tick
);

  logic [SLOW_CNT_W-1:0]  slowCnt;
  logic [INNER_CNT_W-1:0] innerCnt;
  logic [1:0]             extSync;
  logic                   extPrev;
  logic                   slowTick;
  logic                   innerTick;
  logic                   extTick;

  //////////////////////////////////////////////////
  // Dividers, both cleared at point start
  //////////////////////////////////////////////////

  assign slowTick  = (slowCnt == SLOW_CNT_W'(SLOW_TICK_CYCLES - 1));
  assign innerTick = (innerCnt == INNER_CNT_W'(INNER_TICK_CYCLES - 1));

  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      slowCnt  <= '0;
      innerCnt <= '0;
    end else if (restart) begin
      slowCnt  <= '0;
      innerCnt <= '0;
    end else begin
      slowCnt  <= slowTick ? '0 : slowCnt + 1'b1;
      innerCnt <= innerTick ? '0 : innerCnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // External stimulus clock
  //////////////////////////////////////////////////

  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      extSync <= 2'b00;
      extPrev <= 1'b0;
    end else begin
      extSync <= {extSync[0], clkExt};
      extPrev <= extSync[1];
    end
  end

  // Rising edge of the synchronized pin
  assign extTick = extSync[1] & ~extPrev;

  // Trigger mode picks its stimulus, count mode uses the window tick
  assign tick = mode ? (innerClockEnable ? innerTick : extTick) : slowTick;

endmodule

`default_nettype wire

// File: logic/pointCounter.sv
`timescale 1ns/10ps
`default_nettype none

module pointCounter (
  input  wire         Clk_5M,
  input  wire         reset_n,
  scanParamIf.meas    params,
  input  wire         pointStart,
  input  wire         tick,
  input  wire         trigger0b,
  input  wire         trigger1b,
  input  wire         trigger2b,
  input  wire  [15:0] label,
  output logic        fifoWrEn,
  output logic [15:0] fifoDin,
  output logic        pointDone
);

  logic [2:0]  trigSync1;
  logic [2:0]  trigSync2;
  logic        trigHit;
  logic        trigHitPrev;
  logic        active;
  logic        pending;
  logic        writeCount;
  logic [3:0]  delayCnt;
  logic [15:0] tickCnt;
  logic [15:0] hitCnt;
  logic        finish;

  // Any trigger low is a hit
  assign trigHit = ~&trigSync2;
  // Window full and no sample outstanding
  assign finish = active && !pending && (tickCnt == params.cptMax);

  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      trigSync1   <= 3'b111;
      trigSync2   <= 3'b111;
      trigHitPrev <= 1'b0;
      active      <= 1'b0;
      pending     <= 1'b0;
      writeCount  <= 1'b0;
      delayCnt    <= '0;
      tickCnt     <= '0;
      hitCnt      <= '0;
      fifoWrEn    <= 1'b0;
      pointDone   <= 1'b0;
    end else begin
      trigSync1   <= {trigger2b, trigger1b, trigger0b};
      trigSync2   <= trigSync1;
      trigHitPrev <= trigHit;
      // Count word goes one cycle after the label
      writeCount  <= finish;
      fifoWrEn    <= finish | writeCount;
      pointDone   <= finish;
      if (pointStart) begin
        active  <= 1'b1;
        pending <= 1'b0;
        tickCnt <= '0;
        hitCnt  <= '0;
      end else if (finish) begin
        active <= 1'b0;
      end else if (active) begin
        if (tick) begin
          tickCnt <= tickCnt + 1'b1;
        end
        if (params.mode) begin
          // Trigger efficiency, delayed sample after each tick
          if (tick) begin
            pending  <= 1'b1;
            delayCnt <= params.triggerDelay;
          end else if (pending && delayCnt != 4'd0) begin
            delayCnt <= delayCnt - 1'b1;
          end else if (pending) begin
            pending <= 1'b0;
            if (trigHit && hitCnt != 16'hffff) begin
              hitCnt <= hitCnt + 1'b1;
            end
          end
        end else if (trigHit && !trigHitPrev && hitCnt != 16'hffff) begin
          // Count efficiency, saturating edge count
          hitCnt <= hitCnt + 1'b1;
        end
      end
    end
  end

  // Result word mux
  always_ff @(posedge Clk_5M) begin
    if (finish) begin
      fifoDin <= label;
    end else if (writeCount) begin
      fifoDin <= hitCnt;
    end
  end

endmodule

`default_nettype wire

// File: logic/scurveFifo.sv
`timescale 1ns/10ps
`default_nettype none

module scurveFifo
  import scurvePkg::*;
(
  input  wire                   Clk_5M,
  input  wire                   reset_n,
  input  wire                   wrEn,
  input  wire  [15:0]           din,
  input  wire                   rdEn,
  output wire  [15:0]           dout,
  output wire                   empty,
  output wire  [FIFO_CNT_W-1:0] freeCount
);

  logic [15:0]           mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wrPtr;
  logic [FIFO_PTR_W-1:0] rdPtr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  doWrite;
  logic                  doRead;

  // Writes into a full FIFO are dropped
  assign doWrite   = wrEn && (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign doRead    = rdEn && !empty;
  assign empty     = (count == '0);
  assign freeCount = FIFO_CNT_W'(FIFO_DEPTH) - count;
  // Head word always visible
  assign dout      = mem[rdPtr];

  always_ff @(posedge Clk_5M) begin
    if (doWrite) begin
      mem[wrPtr] <= din;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + FIFO_CNT_W'(doWrite) - FIFO_CNT_W'(doRead);
    end
  end

endmodule

`default_nettype wire

// File: logic/scanSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module scanSequencer
  import scurvePkg::*;
(
  input  wire                     Clk_5M,
  input  wire                     reset_n,
  scanParamIf.seq                 params,
  input  wire                     configurationDone,
  input  wire                     pointDone,
  input  wire                     fifoEmpty,
  input  wire  [FIFO_CNT_W-1:0]   fifoFree,
  input  wire  [15:0]             fifoDout,
  input  wire                     externalFifoFull,
  input  wire                     dataTransmitDone,
  output logic                    pointStart,
  output wire  [15:0]             label,
  output wire                     fifoRdEn,
  output wire  [15:0]             dataout,
  output wire                     dataoutEnable,
  output wire  [NUM_CHANNELS-1:0] ctestChnOut,
  output wire  [9:0]              dac10bitOut,
  output wire  [NUM_CHANNELS-1:0] discriminatorMask,
  output logic                    loadStart,
  output wire                     forceExtRaz,
  output wire                     testDone
);

  scanState_t            state;
  logic [CHAN_W-1:0]     curChan;
  logic [9:0]            curDac;
  logic [10:0]           nextDac;
  logic                  dacMore;
  logic                  chanMore;
  logic                  inScan;
  logic [NUM_CHANNELS-1:0] chanOneHot;

  //////////////////////////////////////////////////
  // Step decisions
  //////////////////////////////////////////////////

  // One bit wider so a step past 1023 is caught
  assign nextDac  = {1'b0, curDac} + {1'b0, params.dacStep};
  assign dacMore  = (params.dacStep != 10'd0) && (nextDac <= {1'b0, params.endDac});
  assign chanMore = !params.singleOr64Chn && (curChan != CHAN_W'(NUM_CHANNELS - 1));

  //////////////////////////////////////////////////
  // ASIC configuration outputs
  //////////////////////////////////////////////////

  assign inScan     = (state != IDLE);
  assign chanOneHot = {{(NUM_CHANNELS - 1){1'b0}}, 1'b1} << curChan;
  assign dac10bitOut = curDac;
  assign ctestChnOut = (inScan && params.ctestOrInput) ? chanOneHot : '0;
  assign discriminatorMask = !inScan ? '0 :
                             params.unmaskAllChannel ? '1 : chanOneHot;
  // Hold the ASIC analog reset off only while measuring
  assign forceExtRaz = (state == MEASURE);
  assign testDone    = (state == DONE);
  assign label       = {curChan, curDac};

  // Drain to the external FIFO whenever it has room
  assign fifoRdEn      = !fifoEmpty && !externalFifoFull;
  assign dataoutEnable = fifoRdEn;
  assign dataout       = fifoDout;

  //////////////////////////////////////////////////
  // Scan FSM
  //////////////////////////////////////////////////

  always_ff @(posedge Clk_5M or negedge reset_n) begin
    if (!reset_n) begin
      state      <= IDLE;
      curChan    <= '0;
      curDac     <= '0;
      pointStart <= 1'b0;
      loadStart  <= 1'b0;
    end else begin
      pointStart <= 1'b0;
      loadStart  <= 1'b0;
      case (state)
        IDLE: begin
          if (params.run) begin
            curDac  <= params.startDac;
            curChan <= params.singleOr64Chn ? params.singleTestChannel : '0;
            // Empty DAC range gives no points
            state   <= (params.startDac > params.endDac) ? DRAIN : LOAD;
          end
        end
        LOAD: begin
          // Channel and DAC outputs settled for one cycle already
          loadStart <= 1'b1;
          state     <= WAIT_CFG;
        end
        WAIT_CFG: begin
          // Done level from the last load is stale during the pulse
          if (!loadStart && configurationDone &&
              fifoFree >= FIFO_CNT_W'(WORDS_PER_POINT)) begin
            pointStart <= 1'b1;
            state      <= MEASURE;
          end
        end
        MEASURE: begin
          if (pointDone) begin
            state <= NEXT;
          end
        end
        NEXT: begin
          if (dacMore) begin
            curDac <= nextDac[9:0];
            state  <= LOAD;
          end else if (chanMore) begin
            curChan <= curChan + 1'b1;
            curDac  <= params.startDac;
            state   <= LOAD;
          end else begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (fifoEmpty) begin
            state <= DONE;
          end
        end
        DONE: begin
          // Hold until the host has taken the data
          if (dataTransmitDone) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/scurveTestTop.sv
`timescale 1ns/10ps
`default_nettype none

module scurveTestTop
  import scurvePkg::*;
(
  input  wire                    Clk_5M,
  input  wire                    reset_n,
  // Host scan control
  input  wire                    testStart,
  input  wire                    triggerEfficiencyOrCountEfficiency,
  input  wire                    innerClockEnable,
  input  wire                    singleOr64Chn,
  input  wire [5:0]              singleTestChannel,
  input  wire                    ctestOrInput,
  input  wire                    unmaskAllChannel,
  input  wire [9:0]              startDac,
  input  wire [9:0]              endDac,
  input  wire [9:0]              dacStep,
  input  wire [15:0]             cptMaxIn,
  input  wire [15:0]             counterMaxIn,
  input  wire [3:0]              triggerDelay,
  // ASIC pins
  input  wire                    clkExt,
  input  wire                    trigger0b,
  input  wire                    trigger1b,
  input  wire                    trigger2b,
  // Slow control
  input  wire                    configurationDone,
  output wire [NUM_CHANNELS-1:0] ctestChnOut,
  output wire [9:0]              dac10bitOut,
  output wire [NUM_CHANNELS-1:0] discriminatorMask,
  output wire                    loadStart,
  output wire                    forceExtRaz,
  // External data FIFO
  input  wire                    externalFifoFull,
  output wire [15:0]             dataout,
  output wire                    dataoutEnable,
  // Completion
  output wire                    testDone,
  input  wire                    dataTransmitDone
);

  scanParamIf params ();

  wire                  pointStart;
  wire                  pointDone;
  wire                  tick;
  wire [15:0]           label;
  wire                  fifoWrEn;
  wire [15:0]           fifoDin;
  wire                  fifoRdEn;
  wire [15:0]           fifoDout;
  wire                  fifoEmpty;
  wire [FIFO_CNT_W-1:0] fifoFree;

  scanConfig u_scanConfig (.*);

  // Mode bits come from the latched copy
  testClockGen u_testClockGen (
    .Clk_5M           (Clk_5M),
    .reset_n          (reset_n),
    .mode             (params.mode),
    .innerClockEnable (params.innerClockEnable),
    .restart          (pointStart),
    .clkExt           (clkExt),
    .tick             (tick)
  );

  pointCounter u_pointCounter (.*);

  scurveFifo u_scurveFifo (
    .Clk_5M    (Clk_5M),
    .reset_n   (reset_n),
    .wrEn      (fifoWrEn),
    .din       (fifoDin),
    .rdEn      (fifoRdEn),
    .dout      (fifoDout),
    .empty     (fifoEmpty),
    .freeCount (fifoFree)
  );

  scanSequencer u_scanSequencer (.*);

endmodule

`default_nettype wire

// File: verif/scurveTestTb.sv
`timescale 1ns/10ps
`default_nettype none

module scurveTestTb
  import scurvePkg::*;
();

  // Host side inputs
  logic        Clk_5M = 1'b0;
  logic        reset_n;
  logic        testStart;
  logic        triggerEfficiencyOrCountEfficiency;
  logic        innerClockEnable;
  logic        singleOr64Chn;
  logic [5:0]  singleTestChannel;
  logic        ctestOrInput;
  logic        unmaskAllChannel;
  logic [9:0]  startDac;
  logic [9:0]  endDac;
  logic [9:0]  dacStep;
  logic [15:0] cptMaxIn;
  logic [15:0] counterMaxIn;
  logic [3:0]  triggerDelay;
  logic        dataTransmitDone;
  // ASIC and slow control model inputs
  logic        clkExt = 1'b0;
  logic        trigger0b = 1'b1;
  logic        trigger1b = 1'b1;
  logic        trigger2b = 1'b1;
  logic        configurationDone = 1'b0;
  logic        externalFifoFull = 1'b0;
  // DUT outputs
  wire  [NUM_CHANNELS-1:0] ctestChnOut;
  wire  [9:0]              dac10bitOut;
  wire  [NUM_CHANNELS-1:0] discriminatorMask;
  wire                     loadStart;
  wire                     forceExtRaz;
  wire  [15:0]             dataout;
  wire                     dataoutEnable;
  wire                     testDone;

  // Stimulus kind selects per point levels (0), all low (1) or a periodic pin (2)
  int    stimKind = 0;
  int    extPeriod = 0;
  int    trigPeriod = 8;
  int    fullPct = 30;
  int    scanId = 0;
  int    budget = 100;
  string testName = "reset";

  // Model state
  int          lastScanId = 0;
  int          pointChan = 0;
  int          pointDac = 0;
  int          cfgWait = 0;
  int          trigPhase = 0;
  int          extPhase = 0;
  int          loadsSeen = 0;
  int          wordsSeen = 0;
  int          razSeen = 0;
  int          cyclesRun = 0;
  logic        donePrev = 1'b0;
  logic        razPrev = 1'b0;
  logic [2:0]  trigPins;
  logic [15:0] expWordQ[$];
  int          expTolQ[$];

  scurveTestTop u_scurveTestTop (.*);

  always #100 Clk_5M = ~Clk_5M;

  //////////////////////////////////////////////////
  // Error reporting
  //////////////////////////////////////////////////

  task automatic reportMismatch(input string what, input logic [63:0] expVal,
                                input logic [63:0] actVal);
    $display("CHECK FAILED %s %s: expected %0h actual %0h", testName, what, expVal, actVal);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic reportProblem(input string what);
    $display("ERROR %s: %s", testName, what);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  //////////////////////////////////////////////////
  // Reference model of the scan
  //////////////////////////////////////////////////

  // Points per scan from the DAC range and channel mode
  function automatic int countPoints(input int oneChan, input int firstDac, input int lastDac,
                                     input int step);
    int perChan;
    if (firstDac > lastDac) begin
      perChan = 0;
    end else begin
      perChan = (lastDac - firstDac) / step + 1;
    end
    return (oneChan != 0) ? perChan : perChan * int'(NUM_CHANNELS);
  endfunction

  // ASIC settings expected at a load pulse
  task automatic checkLoad();
    logic [63:0] oneHot;
    logic [63:0] expCtest;
    logic [63:0] expDisc;
    oneHot   = 64'd1 << pointChan;
    expCtest = ctestOrInput ? oneHot : 64'd0;
    expDisc  = unmaskAllChannel ? {64{1'b1}} : oneHot;
    assert (dac10bitOut == 10'(pointDac))
      else reportMismatch("dac at load", 64'(pointDac), 64'(dac10bitOut));
    assert (ctestChnOut == expCtest)
      else reportMismatch("ctest mask", expCtest, ctestChnOut);
    assert (discriminatorMask == expDisc)
      else reportMismatch("discriminator mask", expDisc, discriminatorMask);
  endtask

  // Queue label and count for the point and pick the trigger pin levels
  task automatic queueResult(output logic [2:0] pins);
    int lvl;
    int expCount;
    int tol;
    tol  = 0;
    pins = 3'b111;
    if (stimKind == 2) begin
      // Rounded number of falling edges in the slow tick window
      expCount = (int'(counterMaxIn) * int'(SLOW_TICK_CYCLES) + trigPeriod / 2) / trigPeriod;
      tol = 1;
    end else if (stimKind == 1) begin
      pins = 3'b000;
      expCount = int'(cptMaxIn);
    end else begin
      lvl = $urandom % 4;
      // Level 0 keeps all high, otherwise one pin low
      pins = ~(3'(lvl != 0) << (lvl - 1));
      expCount = (lvl == 0) ? 0 : int'(cptMaxIn);
    end
    expWordQ.push_back({6'(pointChan), 10'(pointDac)});
    expTolQ.push_back(0);
    expWordQ.push_back(16'(expCount));
    expTolQ.push_back(tol);
  endtask

  // DAC steps first and channels after
  task automatic advancePoint();
    if (pointDac + int'(dacStep) <= int'(endDac)) begin
      pointDac = pointDac + int'(dacStep);
    end else begin
      pointChan = pointChan + 1;
      pointDac  = int'(startDac);
    end
  endtask

  task automatic checkWord();
    logic [15:0] expVal;
    int          tol;
    int          diff;
    if (expWordQ.size() == 0) begin
      reportProblem("output word arrived with no result expected");
    end else begin
      expVal = expWordQ.pop_front();
      tol    = expTolQ.pop_front();
      diff   = int'(dataout) - int'(expVal);
      assert (diff >= -tol && diff <= tol)
        else reportMismatch($sformatf("word %0d", wordsSeen), 64'(expVal), 64'(dataout));
      wordsSeen++;
    end
  endtask

  //////////////////////////////////////////////////
  // ASIC, slow control and external FIFO model
  //////////////////////////////////////////////////

  always @(posedge Clk_5M) begin
    // New scan restarts the point walk
    if (scanId != lastScanId) begin
      lastScanId = scanId;
      pointChan  = singleOr64Chn ? int'(singleTestChannel) : 0;
      pointDac   = int'(startDac);
    end
    externalFifoFull <= ($urandom % 100) < fullPct;
    if (loadStart) begin
      checkLoad();
      queueResult(trigPins);
      if (stimKind != 2) begin
        {trigger2b, trigger1b, trigger0b} <= trigPins;
      end
      advancePoint();
      loadsSeen++;
      configurationDone <= 1'b0;
      cfgWait = 1 + $urandom % 10;
    end else if (cfgWait != 0) begin
      cfgWait--;
      if (cfgWait == 0) begin
        configurationDone <= 1'b1;
      end
    end
    // Free running trigger for count efficiency
    if (stimKind == 2) begin
      trigPhase = (trigPhase + 1) % trigPeriod;
      trigger0b <= (trigPhase >= trigPeriod / 2);
      trigger1b <= 1'b1;
      trigger2b <= 1'b1;
    end
    if (dataoutEnable) begin
      checkWord();
    end
    assert (!(dataoutEnable && externalFifoFull))
      else reportProblem("data enable high while external FIFO full");
    // Forced external reset belongs to the measurement only
    if (loadStart || testDone) begin
      assert (!forceExtRaz)
        else reportProblem("external reset forced outside a measurement");
    end
    if (forceExtRaz && !razPrev) begin
      razSeen++;
    end
    razPrev = forceExtRaz;
    if (testDone && !donePrev) begin
      assert (expWordQ.size() == 0)
        else reportProblem("done raised before the last result word");
    end
    donePrev = testDone;
  end

  // External stimulus clock stays off when the period is 0
  always @(posedge Clk_5M) begin
    if (extPeriod == 0) begin
      extPhase = 0;
      clkExt <= 1'b0;
    end else begin
      extPhase = (extPhase + 1) % extPeriod;
      clkExt <= (extPhase < extPeriod / 2);
    end
  end

  // Watchdog
  always @(posedge Clk_5M) begin
    cyclesRun = cyclesRun + 1;
    if (cyclesRun > budget) begin
      $display("ERROR watchdog: run went past %0d cycles without finishing", budget);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
    end
  end

  //////////////////////////////////////////////////
  // Host sequence
  //////////////////////////////////////////////////

  task automatic runScan(input string name, input int trigMode, input int useInner,
                         input int oneChan, input int ctestSel, input int unmaskSel,
                         input int firstDac, input int lastDac, input int step,
                         input int limit, input int tickCycles);
    int points;
    int loadBase;
    int wordBase;
    int razBase;
    @(posedge Clk_5M);
    testName = name;
    triggerEfficiencyOrCountEfficiency <= (trigMode != 0);
    innerClockEnable  <= (useInner != 0);
    singleOr64Chn     <= (oneChan != 0);
    singleTestChannel <= 6'($urandom % NUM_CHANNELS);
    ctestOrInput      <= (ctestSel != 0);
    unmaskAllChannel  <= (unmaskSel != 0);
    startDac          <= 10'(firstDac);
    endDac            <= 10'(lastDac);
    dacStep           <= 10'(step);
    // The unused limit gets noise
    cptMaxIn          <= (trigMode != 0) ? 16'(limit) : 16'($urandom);
    counterMaxIn      <= (trigMode != 0) ? 16'($urandom) : 16'(limit);
    triggerDelay      <= 4'($urandom);
    scanId            <= scanId + 1;
    points   = countPoints(oneChan, firstDac, lastDac, step);
    budget   <= budget + 2 * points * (limit * tickCycles + 200);
    loadBase = loadsSeen;
    wordBase = wordsSeen;
    razBase  = razSeen;
    @(posedge Clk_5M);
    testStart <= 1'b1;
    while (!testDone) begin
      @(posedge Clk_5M);
    end
    // Done must hold while the host has not answered
    repeat (3) begin
      @(posedge Clk_5M);
      assert (testDone) else reportProblem("done dropped before data transmit done");
    end
    assert (expWordQ.size() == 0) else reportProblem("result words missing at done");
    assert (loadsSeen - loadBase == points)
      else reportMismatch("load pulses", 64'(points), 64'(loadsSeen - loadBase));
    assert (wordsSeen - wordBase == 2 * points)
      else reportMismatch("output words", 64'(2 * points), 64'(wordsSeen - wordBase));
    assert (razSeen - razBase == points)
      else reportMismatch("measure windows", 64'(points), 64'(razSeen - razBase));
    dataTransmitDone <= 1'b1;
    testStart        <= 1'b0;
    while (testDone) begin
      @(posedge Clk_5M);
    end
    dataTransmitDone <= 1'b0;
    repeat (4) @(posedge Clk_5M);
  endtask

  initial begin
    int s;
    int step;
    int p;
    void'($urandom(32'h01bc9c3d));
    reset_n           = 1'b0;
    testStart         = 1'b0;
    triggerEfficiencyOrCountEfficiency = 1'b1;
    innerClockEnable  = 1'b1;
    singleOr64Chn     = 1'b1;
    singleTestChannel = 6'd0;
    ctestOrInput      = 1'b0;
    unmaskAllChannel  = 1'b0;
    startDac          = 10'd0;
    endDac            = 10'd0;
    dacStep           = 10'd1;
    cptMaxIn          = 16'd1;
    counterMaxIn      = 16'd1;
    triggerDelay      = 4'd0;
    dataTransmitDone  = 1'b0;
    repeat (8) @(posedge Clk_5M);
    reset_n <= 1'b1;
    repeat (2) @(posedge Clk_5M);
    assert (!dataoutEnable && !loadStart && !testDone && !forceExtRaz)
      else reportProblem("control outputs not low after reset");
    assert (dac10bitOut == 10'd0)
      else reportMismatch("dac after reset", 64'd0, 64'(dac10bitOut));
    assert (ctestChnOut == '0 && discriminatorMask == '0)
      else reportProblem("channel masks not clear after reset");

    // Trigger efficiency on the inner clock with random hit levels
    stimKind <= 0;
    step = 1 + $urandom % 30;
    s    = $urandom % 800;
    runScan("trig_inner", 1, 1, 1, $urandom % 2, $urandom % 2, s,
            s + step * (3 + $urandom % 4) + $urandom % step, step, 10 + $urandom % 20, 46);

    // Trigger efficiency on CLK_EXT with the DAC range ending at the top code
    p = 20 + $urandom % 21;
    stimKind  <= 1;
    extPeriod <= p;
    step = 8 + $urandom % 8;
    runScan("trig_ext", 1, 0, 1, $urandom % 2, $urandom % 2, 990 + $urandom % 10, 1023,
            step, 8 + $urandom % 10, p);
    extPeriod <= 0;

    // Count efficiency with a periodic trigger
    p = 8 + $urandom % 23;
    stimKind   <= 2;
    trigPeriod <= p;
    step = 1 + $urandom % 20;
    s    = $urandom % 1000;
    runScan("count_eff", 0, $urandom % 2, 1, $urandom % 2, $urandom % 2, s, s + step, step,
            1 + $urandom % 2, int'(SLOW_TICK_CYCLES));

    // All 64 channels with one DAC point each
    stimKind <= 0;
    s = $urandom % 1024;
    runScan("all_chan_ctest", 1, 1, 0, 1, 0, s, s, 1 + $urandom % 10, 2, 46);
    s = $urandom % 1024;
    runScan("all_chan_unmask", 1, 1, 0, 0, 1, s, s, 1 + $urandom % 10, 2, 46);

    // Short points against a mostly full external FIFO
    fullPct <= 90;
    s = $urandom % 200;
    runScan("back_pressure", 1, 1, 1, $urandom % 2, $urandom % 2, s, s + 3 * 39, 3, 1, 46);
    fullPct <= 30;

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/scurvePkg.sv
logic/scanParamIf.sv
logic/scanConfig.sv
logic/testClockGen.sv
logic/pointCounter.sv
logic/scurveFifo.sv
logic/scanSequencer.sv
logic/scurveTestTop.sv
verif/scurveTestTb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module scurveTestTb -o simv > sim.log 2>&1 \
  && ./obj_dir/simv >> sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
